/* src/ppu_vga_pkg.sv */
package ppu_vga_pkg;

    typedef enum logic [2:0] {
        HS_VIS,
        HS_FP,
        HS_PULSE,
        HS_BP,
        HS_IDLE
    } vga_hs_state_t;

    typedef enum logic [2:0] {
        VS_PRE,
        VS_VIS,
        VS_FP,
        VS_PULSE,
        VS_BP
    } vga_vs_state_t;

    // horizontal, in pixel ticks
    localparam logic [9:0] H_LAST      = 10'd340;
    localparam logic [9:0] H_VIS_END   = 10'd255;
    localparam logic [9:0] H_FP_END    = 10'd262;
    localparam logic [9:0] H_PULSE_END = 10'd303;
    localparam logic [9:0] H_BP_END    = 10'd323;

    // vertical, in lines
    localparam logic [9:0] V_LAST      = 10'd523;
    localparam logic [9:0] V_PRE_END   = 10'd3;
    localparam logic [9:0] V_VIS_END   = 10'd483;
    localparam logic [9:0] V_FP_END    = 10'd493;
    localparam logic [9:0] V_PULSE_END = 10'd495;

    typedef logic [5:0] pixel_idx_t;

    typedef struct packed {
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
    } rgb332_t;

    typedef struct packed {
        logic [1:0] rsvd;
        pixel_idx_t idx;
    } pix_lane_t;

    // same write word, decoded by target address
    typedef union packed {
        pix_lane_t [3:0] pix;       // lane 0 is the lowest pixel
        struct packed {
            logic [17:0] rsvd_hi;
            pixel_idx_t  backdrop;
            logic [6:0]  rsvd_lo;
            logic        crt_en;
        } ctrl;
    } axil_wdata_u;

    // pixel words from 0x000 up to 0x0fc for a full line
    localparam logic [11:0] ADDR_PIX_BASE = 12'h000;
    localparam logic [11:0] ADDR_CTRL     = 12'h100;
    localparam logic [11:0] ADDR_SWAP     = 12'h104;
    localparam logic [11:0] ADDR_STATUS   = 12'h108;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // nes colours packed as {r, g, b}
    localparam logic [7:0] NES_PAL [0:63] = '{
        8'h6D, 8'h22, 8'h02, 8'h42, 8'h81, 8'hA0, 8'hA0, 8'h60,
        8'h44, 8'h08, 8'h08, 8'h04, 8'h05, 8'h00, 8'h00, 8'h00,
        8'hB6, 8'h0F, 8'h27, 8'h83, 8'hA2, 8'hE1, 8'hC4, 8'hC8,
        8'h8C, 8'h10, 8'h14, 8'h10, 8'h12, 8'h00, 8'h00, 8'h00,
        8'hFF, 8'h37, 8'h53, 8'hB3, 8'hEF, 8'hEE, 8'hED, 8'hF0,
        8'hF4, 8'h98, 8'h59, 8'h5E, 8'h1F, 8'h00, 8'h00, 8'h00,
        8'hFF, 8'hBF, 8'hDB, 8'hDB, 8'hFB, 8'hFB, 8'hF6, 8'hFA,
        8'hFE, 8'hFE, 8'hBE, 8'hBF, 8'h9F, 8'h00, 8'h00, 8'h00
    };

    function automatic rgb332_t nes_palette(input pixel_idx_t idx);
        return rgb332_t'(NES_PAL[idx]);
    endfunction

endpackage

/* src/line_wr_if.sv */
`timescale 1ns/1ps

// host side writes pixel words and requests bank swaps
interface line_wr_if;

    logic                              wr_en;
    logic [5:0]                        wr_word;    // word index, 4 pixels each
    ppu_vga_pkg::pixel_idx_t [3:0]     wr_pixels;
    logic                              swap_req;

    modport host (
        output wr_en,
        output wr_word,
        output wr_pixels,
        output swap_req
    );

    modport buffer (
        input wr_en,
        input wr_word,
        input wr_pixels,
        input swap_req
    );

endinterface

/* src/axil_pixel_port.sv */
`timescale 1ns/1ps

module axil_pixel_port #(
    parameter int LINE_PIXELS = 256,
    parameter int ADDR_W      = 12
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic [ADDR_W-1:0]          awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [ADDR_W-1:0]          araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,

    line_wr_if.host                    lw,
    input  logic                       swap_pending,
    input  logic [9:0]                 row,
    input  ppu_vga_pkg::vga_vs_state_t vs_state,
    output logic                       crt_en,
    output ppu_vga_pkg::pixel_idx_t    backdrop
);

    ppu_vga_pkg::axil_wdata_u wd;
    ppu_vga_pkg::axil_wdata_u ctrl_rd;
    logic [ADDR_W-1:0] pix_off;
    logic wr_hs, rd_hs;
    logic aw_is_pix, aw_is_ctrl, aw_is_swap;
    logic [31:0] rd_word;
    logic        rd_ok;

    assign wd      = wdata;
    assign wr_hs   = awready && awvalid && wvalid;
    assign rd_hs   = arready && arvalid;
    assign pix_off = awaddr - ADDR_W'(ppu_vga_pkg::ADDR_PIX_BASE);

    assign aw_is_pix  = (awaddr >= ADDR_W'(ppu_vga_pkg::ADDR_PIX_BASE)) &&
                        (pix_off < ADDR_W'(LINE_PIXELS));
    assign aw_is_ctrl = awaddr == ADDR_W'(ppu_vga_pkg::ADDR_CTRL);
    assign aw_is_swap = awaddr == ADDR_W'(ppu_vga_pkg::ADDR_SWAP);

    // write channel: accept aw+w together, one beat at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lw.wr_en    <= 1'b0;
            lw.swap_req <= 1'b0;
            crt_en      <= 1'b0;
            backdrop    <= '0;
        end else begin
            lw.wr_en    <= wr_hs && aw_is_pix;
            lw.swap_req <= wr_hs && aw_is_swap;
            if (wr_hs && aw_is_ctrl) begin
                if (wstrb[0]) crt_en <= wd.ctrl.crt_en;
                if (wstrb[1]) backdrop <= wd.ctrl.backdrop;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            lw.wr_word <= 6'(pix_off >> 2);
            for (int k = 0; k < 4; k++) begin
                lw.wr_pixels[k] <= wd.pix[k].idx;
            end
            bresp <= (aw_is_pix || aw_is_ctrl || aw_is_swap) ?
                     ppu_vga_pkg::RESP_OKAY : ppu_vga_pkg::RESP_SLVERR;
        end
    end

    // read data, pixel region is write only
    always_comb begin
        ctrl_rd               = '0;
        ctrl_rd.ctrl.crt_en   = crt_en;
        ctrl_rd.ctrl.backdrop = backdrop;
        rd_word = '0;
        rd_ok   = 1'b0;
        if (araddr == ADDR_W'(ppu_vga_pkg::ADDR_CTRL)) begin
            rd_word = ctrl_rd;
            rd_ok   = 1'b1;
        end else if (araddr == ADDR_W'(ppu_vga_pkg::ADDR_STATUS)) begin
            rd_word = {14'd0, swap_pending, vs_state != ppu_vga_pkg::VS_VIS, 6'd0, row};
            rd_ok   = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_ok ? ppu_vga_pkg::RESP_OKAY : ppu_vga_pkg::RESP_SLVERR;
        end
    end

    a_bvalid_after_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(bvalid) |-> $past(awready && wready && awvalid && wvalid)
    );

endmodule

/* src/scanline_buffer.sv */
`timescale 1ns/1ps

module scanline_buffer #(
    parameter  int LINE_PIXELS = 256,
    localparam int IDX_W       = $clog2(LINE_PIXELS)
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clk_en,
    line_wr_if.buffer               lw,
    input  logic                    line_end,
    input  logic [IDX_W-1:0]        rd_idx,
    output ppu_vga_pkg::pixel_idx_t rd_pixel,
    output logic                    swap_pending
);

    ppu_vga_pkg::pixel_idx_t mem [2][LINE_PIXELS];
    logic front_sel;   // bank being displayed

    // host fills the back bank
    always_ff @(posedge clk) begin
        if (lw.wr_en) begin
            for (int k = 0; k < 4; k++) begin
                mem[~front_sel][IDX_W'(lw.wr_word * 4 + k)] <= lw.wr_pixels[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            rd_pixel <= mem[front_sel][rd_idx];
        end
    end

    // swap waits for the end of the current line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            front_sel    <= 1'b0;
            swap_pending <= 1'b0;
        end else begin
            if (line_end && swap_pending) begin
                front_sel <= ~front_sel;
            end
            if (lw.swap_req) begin
                swap_pending <= 1'b1;
            end else if (line_end) begin
                swap_pending <= 1'b0;
            end
        end
    end

    a_wr_word_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        lw.wr_en |-> (int'(lw.wr_word) < LINE_PIXELS / 4)
    );

endmodule

/* src/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clk_en,
    output logic [9:0]                 row,
    output logic [9:0]                 col,
    output ppu_vga_pkg::vga_hs_state_t hs_state,
    output ppu_vga_pkg::vga_vs_state_t vs_state,
    output logic                       line_end
);

    ppu_vga_pkg::vga_hs_state_t hs_next;
    ppu_vga_pkg::vga_vs_state_t vs_next;
    logic last_col;

    assign last_col = col == ppu_vga_pkg::H_LAST;
    assign line_end = clk_en && last_col;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (clk_en) begin
            col <= last_col ? 10'd0 : col + 10'd1;
            if (last_col) begin
                row <= (row == ppu_vga_pkg::V_LAST) ? 10'd0 : row + 10'd1;
            end
        end
    end

    always_comb begin
        case (hs_state)
            ppu_vga_pkg::HS_VIS:
                hs_next = (col < ppu_vga_pkg::H_VIS_END) ? ppu_vga_pkg::HS_VIS
                                                         : ppu_vga_pkg::HS_FP;
            ppu_vga_pkg::HS_FP:
                hs_next = (col < ppu_vga_pkg::H_FP_END) ? ppu_vga_pkg::HS_FP
                                                        : ppu_vga_pkg::HS_PULSE;
            ppu_vga_pkg::HS_PULSE:
                hs_next = (col < ppu_vga_pkg::H_PULSE_END) ? ppu_vga_pkg::HS_PULSE
                                                           : ppu_vga_pkg::HS_BP;
            ppu_vga_pkg::HS_BP:
                hs_next = (col < ppu_vga_pkg::H_BP_END) ? ppu_vga_pkg::HS_BP
                                                        : ppu_vga_pkg::HS_IDLE;
            ppu_vga_pkg::HS_IDLE:
                hs_next = last_col ? ppu_vga_pkg::HS_VIS : ppu_vga_pkg::HS_IDLE;
            default:
                hs_next = ppu_vga_pkg::HS_VIS;
        endcase
    end

    // vertical moves only on the last tick of a line
    always_comb begin
        vs_next = vs_state;
        if (last_col) begin
            case (vs_state)
                ppu_vga_pkg::VS_PRE:
                    if (row == ppu_vga_pkg::V_PRE_END) vs_next = ppu_vga_pkg::VS_VIS;
                ppu_vga_pkg::VS_VIS:
                    if (row == ppu_vga_pkg::V_VIS_END) vs_next = ppu_vga_pkg::VS_FP;
                ppu_vga_pkg::VS_FP:
                    if (row == ppu_vga_pkg::V_FP_END) vs_next = ppu_vga_pkg::VS_PULSE;
                ppu_vga_pkg::VS_PULSE:
                    if (row == ppu_vga_pkg::V_PULSE_END) vs_next = ppu_vga_pkg::VS_BP;
                ppu_vga_pkg::VS_BP:
                    if (row == ppu_vga_pkg::V_LAST) vs_next = ppu_vga_pkg::VS_PRE;
                default:
                    vs_next = ppu_vga_pkg::VS_PRE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_state <= ppu_vga_pkg::HS_VIS;
            vs_state <= ppu_vga_pkg::VS_PRE;
        end else if (clk_en) begin
            hs_state <= hs_next;
            vs_state <= vs_next;
        end
    end

    a_col_range: assert property (
        @(posedge clk) disable iff (!rst_n) col <= ppu_vga_pkg::H_LAST
    );

    a_row_range: assert property (
        @(posedge clk) disable iff (!rst_n) row <= ppu_vga_pkg::V_LAST
    );

endmodule

/* src/vga_pixel_out.sv */
`timescale 1ns/1ps

module vga_pixel_out #(
    parameter  int LINE_PIXELS = 256,
    localparam int IDX_W       = $clog2(LINE_PIXELS)
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clk_en,
    input  logic [9:0]                 row,
    input  logic [9:0]                 col,
    input  ppu_vga_pkg::vga_hs_state_t hs_state,
    input  ppu_vga_pkg::vga_vs_state_t vs_state,
    output logic [IDX_W-1:0]           rd_idx,
    input  ppu_vga_pkg::pixel_idx_t    rd_pixel,
    input  logic                       crt_en,
    input  ppu_vga_pkg::pixel_idx_t    backdrop,
    output logic                       vsync_n,
    output logic                       hsync_n,
    output logic [2:0]                 vga_r,
    output logic [2:0]                 vga_g,
    output logic [1:0]                 vga_b,
    output logic                       blank
);

    logic visible;
    logic show_pix;     // lines up with rd_pixel
    ppu_vga_pkg::rgb332_t color;

    assign rd_idx  = col[IDX_W-1:0];
    assign visible = (vs_state == ppu_vga_pkg::VS_VIS) &&
                     (hs_state == ppu_vga_pkg::HS_VIS);

    // one tick behind timing, same as the buffer read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync_n  <= 1'b1;
            vsync_n  <= 1'b1;
            blank    <= 1'b1;
            show_pix <= 1'b0;
        end else if (clk_en) begin
            hsync_n  <= hs_state != ppu_vga_pkg::HS_PULSE;
            vsync_n  <= vs_state != ppu_vga_pkg::VS_PULSE;
            blank    <= !visible;
            show_pix <= visible && (!row[0] || !crt_en);   // odd rows dark in crt mode
        end
    end

    assign color = ppu_vga_pkg::nes_palette(show_pix ? rd_pixel : backdrop);
    assign vga_r = color.r;
    assign vga_g = color.g;
    assign vga_b = color.b;

endmodule

/* src/ppu_vga_top.sv */
`timescale 1ns/1ps

module ppu_vga_top #(
    parameter int LINE_PIXELS = 256,
    parameter int ADDR_W      = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              clk_en,

    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,

    output logic              vsync_n,
    output logic              hsync_n,
    output logic [2:0]        vga_r,
    output logic [2:0]        vga_g,
    output logic [1:0]        vga_b,
    output logic              blank
);

    localparam int IDX_W = $clog2(LINE_PIXELS);

    logic [9:0] row, col;
    logic       line_end;
    logic       swap_pending;
    logic       crt_en;
    logic [IDX_W-1:0]           rd_idx;
    ppu_vga_pkg::pixel_idx_t    rd_pixel;
    ppu_vga_pkg::pixel_idx_t    backdrop;
    ppu_vga_pkg::vga_hs_state_t hs_state;
    ppu_vga_pkg::vga_vs_state_t vs_state;

    line_wr_if lw_i ();

    axil_pixel_port #(.LINE_PIXELS(LINE_PIXELS), .ADDR_W(ADDR_W)) port_i (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .lw(lw_i.host),
        .swap_pending, .row, .vs_state, .crt_en, .backdrop
    );

    scanline_buffer #(.LINE_PIXELS(LINE_PIXELS)) buf_i (
        .clk, .rst_n, .clk_en,
        .lw(lw_i.buffer),
        .line_end, .rd_idx, .rd_pixel, .swap_pending
    );

    vga_timing timing_i (
        .clk, .rst_n, .clk_en,
        .row, .col, .hs_state, .vs_state, .line_end
    );

    vga_pixel_out #(.LINE_PIXELS(LINE_PIXELS)) out_i (
        .clk, .rst_n, .clk_en,
        .row, .col, .hs_state, .vs_state,
        .rd_idx, .rd_pixel, .crt_en, .backdrop,
        .vsync_n, .hsync_n, .vga_r, .vga_g, .vga_b, .blank
    );

endmodule

/* testbench/ppu_vga_tb.sv */
`timescale 1ns/1ps

module ppu_vga_tb;

    localparam int H_TOTAL = 341;
    localparam int V_TOTAL = 524;
    localparam int LIMIT   = 4 * V_TOTAL * H_TOTAL * 2 + 5000;
    localparam logic [1:0] OKAY     = 2'b00;
    localparam logic [1:0] SLVERR   = 2'b10;
    localparam logic [5:0] BACKDROP = 6'h21;

    // nes colours as {r, g, b} 3-3-2
    localparam logic [7:0] PAL_MODEL [64] = '{
        8'h6D, 8'h22, 8'h02, 8'h42, 8'h81, 8'hA0, 8'hA0, 8'h60,
        8'h44, 8'h08, 8'h08, 8'h04, 8'h05, 8'h00, 8'h00, 8'h00,
        8'hB6, 8'h0F, 8'h27, 8'h83, 8'hA2, 8'hE1, 8'hC4, 8'hC8,
        8'h8C, 8'h10, 8'h14, 8'h10, 8'h12, 8'h00, 8'h00, 8'h00,
        8'hFF, 8'h37, 8'h53, 8'hB3, 8'hEF, 8'hEE, 8'hED, 8'hF0,
        8'hF4, 8'h98, 8'h59, 8'h5E, 8'h1F, 8'h00, 8'h00, 8'h00,
        8'hFF, 8'hBF, 8'hDB, 8'hDB, 8'hFB, 8'hFB, 8'hF6, 8'hFA,
        8'hFE, 8'hFE, 8'hBE, 8'hBF, 8'h9F, 8'h00, 8'h00, 8'h00
    };

    logic clk, rst_n, clk_en;
    logic [11:0] awaddr, araddr;
    logic awvalid, wvalid, bready, arvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic awready, wready, bvalid, arready, rvalid;
    logic [1:0] bresp, rresp;
    logic vsync_n, hsync_n, blank;
    logic [2:0] vga_r, vga_g;
    logic [1:0] vga_b;

    int errors;
    int cycles;
    int ticks;           // clk_en ticks since reset release
    logic [31:0] lfsr;
    logic [5:0] line_pix [256];

    ppu_vga_top #(.LINE_PIXELS(256), .ADDR_W(12)) dut_i (.*);

    always #20 clk = ~clk;

    always @(negedge clk) clk_en <= ~clk_en;   // one pixel every two clocks

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ticks <= 0;
        end else if (clk_en) begin
            ticks <= ticks + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d clock cycles", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_idx(output logic [5:0] idx);
        for (int b = 0; b < 6; b++) begin
            idx[b] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // position of the timing state behind the current outputs
    function automatic int cur_col();
        return (ticks - 1) % H_TOTAL;
    endfunction

    function automatic int cur_row();
        return ((ticks - 1) / H_TOTAL) % V_TOTAL;
    endfunction

    function automatic logic sync_level(input bit vert);
        return vert ? vsync_n : hsync_n;
    endfunction

    function automatic logic [31:0] ctrl_word(input logic crt, input logic [5:0] bd);
        return {18'd0, bd, 7'd0, crt};
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // returns at the falling edge after the next pixel tick
    task automatic wait_tick();
        do @(negedge clk); while (!clk_en);
    endtask

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp, input int hold);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        do @(negedge clk); while (!(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        check_val("bvalid", 1, bvalid);
        check_val("bresp", exp_resp, bresp);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_val("bvalid", 1, bvalid);   // stalled by bready
        end
        bready = 1'b1;
        do @(negedge clk); while (bvalid);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, input logic [1:0] exp_resp,
                             output logic [31:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(negedge clk); while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        check_val("rvalid", 1, rvalid);
        check_val("rresp", exp_resp, rresp);
        data = rdata;
        do @(negedge clk); while (rvalid);
        rready = 1'b0;
    endtask

    task automatic check_idle();
        check_val("hsync_n", 1, hsync_n);
        check_val("vsync_n", 1, vsync_n);
        check_val("blank", 1, blank);
        check_val("awready", 0, awready);
        check_val("wready", 0, wready);
        check_val("bvalid", 0, bvalid);
        check_val("arready", 0, arready);
        check_val("rvalid", 0, rvalid);
    endtask

    task automatic wait_line_start(input bit odd);
        do wait_tick();
        while (!(cur_col() == 0 && cur_row() >= 4 && cur_row() <= 483 &&
                 cur_row() % 2 == odd));
    endtask

    // whole line from col 0 of a visible row
    task automatic check_line(input bit show, input logic [5:0] bd);
        logic [5:0] idx;
        for (int c = 0; c < H_TOTAL; c++) begin
            if (c > 0) begin
                wait_tick();
            end
            idx = (show && c < 256) ? line_pix[c] : bd;
            check_val("blank", c >= 256, blank);
            check_val("vga_rgb", PAL_MODEL[idx], {vga_r, vga_g, vga_b});
        end
    endtask

    task automatic measure_sync(input bit vert, output int low_ticks, output int period);
        logic prev, cur;
        wait_tick();
        cur = sync_level(vert);
        do begin
            prev = cur;
            wait_tick();
            cur = sync_level(vert);
        end while (!(prev && !cur));
        low_ticks = 0;
        while (!cur) begin
            low_ticks++;
            wait_tick();
            cur = sync_level(vert);
        end
        period = low_ticks;
        do begin
            period++;
            prev = cur;
            wait_tick();
            cur = sync_level(vert);
        end while (!(prev && !cur));
    endtask

    task automatic reset_test();
        rst_n = 1'b0;
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        rst_n = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
    endtask

    task automatic reg_test();
        logic [31:0] rd;
        axil_write(12'h100, ctrl_word(1'b1, BACKDROP), OKAY, 0);
        axil_read(12'h100, OKAY, rd);
        check_val("ctrl rdata", ctrl_word(1'b1, BACKDROP), rd);
        axil_write(12'h200, 32'hffff_ffff, SLVERR, 0);
        axil_read(12'h000, SLVERR, rd);
        axil_read(12'h100, OKAY, rd);   // unmapped write must not touch ctrl
        check_val("ctrl rdata", ctrl_word(1'b1, BACKDROP), rd);
        axil_write(12'h100, ctrl_word(1'b1, BACKDROP), OKAY, 6);
    endtask

    task automatic line_test();
        logic [31:0] word, rd;
        int polls;
        for (int i = 0; i < 256; i++) begin
            rand_idx(line_pix[i]);
        end
        for (int w = 0; w < 64; w++) begin
            word = {2'b0, line_pix[4*w+3], 2'b0, line_pix[4*w+2],
                    2'b0, line_pix[4*w+1], 2'b0, line_pix[4*w]};
            axil_write(12'(4 * w), word, OKAY, 0);
        end
        axil_write(12'h104, 32'd0, OKAY, 0);
        polls = 0;
        do begin
            axil_read(12'h108, OKAY, rd);
            polls++;
        end while (rd[17] && polls < 1000);
        assert (!rd[17]) else begin
            errors++;
            $display("bank swap still pending after %0d status reads", polls);
        end
        // vblank flag follows the row it was read with
        check_val("status vblank", (rd[9:0] < 10'd4 || rd[9:0] > 10'd483), rd[16]);
        wait_line_start(1'b0);
        check_line(1'b1, BACKDROP);
    endtask

    task automatic crt_test();
        axil_write(12'h100, ctrl_word(1'b1, BACKDROP), OKAY, 0);
        wait_line_start(1'b1);
        check_line(1'b0, BACKDROP);     // odd row shows backdrop only
        axil_write(12'h100, ctrl_word(1'b0, BACKDROP), OKAY, 0);
        wait_line_start(1'b1);
        check_line(1'b1, BACKDROP);
    endtask

    task automatic sync_test();
        int low, period;
        measure_sync(1'b0, low, period);
        check_val("hsync_n low ticks", 41, low);
        check_val("hsync_n period", H_TOTAL, period);
        measure_sync(1'b1, low, period);
        check_val("vsync_n low ticks", 2 * H_TOTAL, low);
        check_val("vsync_n period", V_TOTAL * H_TOTAL, period);
    endtask

    initial begin
        clk     = 1'b0;
        clk_en  = 1'b0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        lfsr    = 32'h430b8683;
        errors  = 0;
        cycles  = 0;
        reset_test();
        reg_test();
        line_test();
        crt_test();
        sync_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* ppu_vga_top.f */
src/ppu_vga_pkg.sv
src/line_wr_if.sv
src/axil_pixel_port.sv
src/scanline_buffer.sv
src/vga_timing.sv
src/vga_pixel_out.sv
src/ppu_vga_top.sv
testbench/ppu_vga_tb.sv
